//--- dma_top.f
source/dma_pkg.sv
source/dma_fifo.sv
source/dma_master.sv
source/dma_regs.sv
source/dma_top.sv
verif/axi_mem_model.sv
verif/dma_properties.sv
verif/dma_tb.sv

//--- source/dma_fifo.sv
`timescale 1ns/1ps

module dma_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            clr_i,
    input  logic            wen_i,
    input  logic            ren_i,
    input  dma_pkg::data_t  data_i,
    output dma_pkg::data_t  data_o,
    output logic            empty_o,
    output logic            full_o
);
    import dma_pkg::*;

    localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

    data_t mem [DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr_r;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_r;
    logic [FIFO_DEPTH_LOG2:0]   count_r;

    logic do_wr;
    logic do_rd;

    assign do_wr = wen_i && !full_o;
    assign do_rd = ren_i && !empty_o;

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr_r] <= data_i;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else if (clr_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            // simultaneous read and write keeps the count
            case ({do_wr, do_rd})
                2'b10:   count_r <= count_r + 1'b1;
                2'b01:   count_r <= count_r - 1'b1;
                default: ;
            endcase
        end
    end

    // head word falls through
    assign data_o  = mem[rd_ptr_r];
    assign empty_o = (count_r == '0);
    assign full_o  = (count_r == DEPTH[FIFO_DEPTH_LOG2:0]);

endmodule

//--- source/dma_master.sv
`timescale 1ns/1ps

module dma_master #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                dma_en_i,
    input  dma_pkg::addr_t      src_addr_i,
    input  dma_pkg::addr_t      dst_addr_i,
    input  dma_pkg::qty_t       data_qty_i,
    output logic                dma_fin_o,
    // read address channel
    output dma_pkg::addr_t      araddr_o,
    output dma_pkg::axi_len_t   arlen_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    // read data channel
    input  dma_pkg::data_t      rdata_i,
    input  logic                rvalid_i,
    input  logic                rlast_i,
    output logic                rready_o,
    // write address channel
    output dma_pkg::addr_t      awaddr_o,
    output dma_pkg::axi_len_t   awlen_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    // write data channel
    output dma_pkg::data_t      wdata_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    // write response channel
    input  logic                bvalid_i,
    output logic                bready_o
);
    import dma_pkg::*;

    dma_state_e state_r;
    dma_state_e state_nxt;

    qty_t     rem_qty_r;
    axi_len_t burst_len_r;
    axi_len_t beat_cnt_r;
    addr_t    src_addr_r;
    addr_t    dst_addr_r;
    logic     rd_done_r;

    // handshakes
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    qty_t  burst_beats;
    addr_t burst_bytes;
    qty_t  next_rem;

    data_t fifo_dout;
    logic  fifo_wen;
    logic  fifo_ren;
    logic  fifo_empty;
    logic  fifo_full;

    // smaller of the count and the burst limit, as beats minus one
    function automatic axi_len_t len_of(qty_t qty);
        if (qty > qty_t'(MAX_BURST_BEATS)) begin
            return axi_len_t'(MAX_BURST_BEATS - 1);
        end
        return axi_len_t'(qty - qty_t'(1));
    endfunction

    assign ar_hs = arvalid_o && arready_i;
    assign r_hs  = rvalid_i && rready_o;
    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bvalid_i && bready_o;

    assign burst_beats = qty_t'(burst_len_r) + qty_t'(1);
    assign burst_bytes = addr_t'(burst_beats) * addr_t'(BYTES_PER_BEAT);
    assign next_rem    = rem_qty_r - burst_beats;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            IDLE:    if (dma_en_i) state_nxt = CHECK;
            CHECK:   state_nxt = (rem_qty_r != '0) ? ADDR_RD : FIN;
            ADDR_RD: if (ar_hs) state_nxt = ADDR_WR;
            ADDR_WR: if (aw_hs) state_nxt = DATA;
            DATA:    if (w_hs && wlast_o) state_nxt = RESP;
            RESP:    if (b_hs) state_nxt = (next_rem == '0) ? FIN : ADDR_RD;
            FIN:     state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // remaining count and burst length, updated per response
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem_qty_r   <= '0;
            burst_len_r <= '0;
        end else if (state_r == IDLE && dma_en_i) begin
            rem_qty_r <= data_qty_i;
        end else if (state_r == CHECK) begin
            burst_len_r <= len_of(rem_qty_r);
        end else if (b_hs) begin
            rem_qty_r   <= next_rem;
            burst_len_r <= len_of(next_rem);
        end
    end

    // INCR addresses step by the byte length of the finished burst
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_addr_r <= '0;
            dst_addr_r <= '0;
        end else if (state_r == IDLE && dma_en_i) begin
            src_addr_r <= src_addr_i;
            dst_addr_r <= dst_addr_i;
        end else if (b_hs) begin
            src_addr_r <= src_addr_r + burst_bytes;
            dst_addr_r <= dst_addr_r + burst_bytes;
        end
    end

    // write beat counter for wlast
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt_r <= '0;
        end else if (aw_hs) begin
            beat_cnt_r <= '0;
        end else if (w_hs) begin
            beat_cnt_r <= beat_cnt_r + axi_len_t'(1);
        end
    end

    // read burst finished, no more beats to accept
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_done_r <= 1'b0;
        end else if (ar_hs) begin
            rd_done_r <= 1'b0;
        end else if (r_hs && rlast_i) begin
            rd_done_r <= 1'b1;
        end
    end

    assign arvalid_o = (state_r == ADDR_RD);
    assign awvalid_o = (state_r == ADDR_WR);
    assign bready_o  = (state_r == RESP);
    // fifo level drives both data channels
    assign rready_o  = (state_r == DATA) && !fifo_full && !rd_done_r;
    assign wvalid_o  = (state_r == DATA) && !fifo_empty;

    assign araddr_o = src_addr_r;
    assign arlen_o  = burst_len_r;
    assign awaddr_o = dst_addr_r;
    assign awlen_o  = burst_len_r;
    assign wdata_o  = fifo_dout;
    assign wlast_o  = (beat_cnt_r == burst_len_r);

    assign dma_fin_o = (state_r == FIN);

    assign fifo_wen = (state_r == DATA) && r_hs;
    assign fifo_ren = (state_r == DATA) && !fifo_empty && wready_i;

    dma_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_dma_fifo (
        .clk     (clk),
        .rst     (rst),
        .clr_i   (dma_fin_o),
        .wen_i   (fifo_wen),
        .ren_i   (fifo_ren),
        .data_i  (rdata_i),
        .data_o  (fifo_dout),
        .empty_o (fifo_empty),
        .full_o  (fifo_full)
    );

endmodule

//--- source/dma_pkg.sv
package dma_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [31:0] qty_t;

    // AXI burst length, beats minus one
    typedef logic [7:0]  axi_len_t;

    typedef logic [1:0]  reg_addr_t;

    // burst limits for 32-bit INCR bursts
    localparam int MAX_BURST_BEATS = 256;
    localparam int BYTES_PER_BEAT  = 4;

    // register map
    localparam reg_addr_t REG_SRC  = 2'd0;
    localparam reg_addr_t REG_DST  = 2'd1;
    localparam reg_addr_t REG_QTY  = 2'd2;
    localparam reg_addr_t REG_CTRL = 2'd3;

    // burst sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CHECK,
        ADDR_RD,
        ADDR_WR,
        DATA,
        RESP,
        FIN
    } dma_state_e;

endpackage

//--- source/dma_regs.sv
`timescale 1ns/1ps

module dma_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                reg_we_i,
    input  dma_pkg::reg_addr_t  reg_addr_i,
    input  dma_pkg::data_t      reg_wdata_i,
    output dma_pkg::data_t      reg_rdata_o,
    input  logic                dma_fin_i,
    output logic                dma_en_o,
    output dma_pkg::addr_t      src_addr_o,
    output dma_pkg::addr_t      dst_addr_o,
    output dma_pkg::qty_t       data_qty_o,
    output logic                irq_o
);
    import dma_pkg::*;

    addr_t src_r;
    addr_t dst_r;
    qty_t  qty_r;
    logic  busy_r;
    logic  irq_r;
    logic  start_r;

    logic  ctrl_we;
    logic  start_req;
    logic  irq_clr;

    assign ctrl_we   = reg_we_i && (reg_addr_i == REG_CTRL);
    // start only counts when the engine is idle
    assign start_req = ctrl_we && reg_wdata_i[0] && !busy_r;
    assign irq_clr   = ctrl_we && reg_wdata_i[1];

    // programmable values, frozen during a copy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_r <= '0;
            dst_r <= '0;
            qty_r <= '0;
        end else if (reg_we_i && !busy_r) begin
            case (reg_addr_i)
                REG_SRC: src_r <= reg_wdata_i;
                REG_DST: dst_r <= reg_wdata_i;
                REG_QTY: qty_r <= reg_wdata_i;
                default: ;
            endcase
        end
    end

    // one-cycle start pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_r <= 1'b0;
        end else begin
            start_r <= start_req;
        end
    end

    // busy from start write until fin
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_r <= 1'b0;
        end else if (start_req) begin
            busy_r <= 1'b1;
        end else if (dma_fin_i) begin
            busy_r <= 1'b0;
        end
    end

    // interrupt latch, fin wins over a clear in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_r <= 1'b0;
        end else if (dma_fin_i) begin
            irq_r <= 1'b1;
        end else if (irq_clr) begin
            irq_r <= 1'b0;
        end
    end

    // readback mux
    always_comb begin
        case (reg_addr_i)
            REG_SRC: reg_rdata_o = src_r;
            REG_DST: reg_rdata_o = dst_r;
            REG_QTY: reg_rdata_o = qty_r;
            default: reg_rdata_o = {30'd0, irq_r, busy_r};
        endcase
    end

    assign dma_en_o   = start_r;
    assign src_addr_o = src_r;
    assign dst_addr_o = dst_r;
    assign data_qty_o = qty_r;
    assign irq_o      = irq_r;

endmodule

//--- source/dma_top.sv
`timescale 1ns/1ps

module dma_top #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                clk,
    input  logic                rst,
    // register port
    input  logic                reg_we_i,
    input  dma_pkg::reg_addr_t  reg_addr_i,
    input  dma_pkg::data_t      reg_wdata_i,
    output dma_pkg::data_t      reg_rdata_o,
    output logic                irq_o,
    // AXI master port
    output dma_pkg::addr_t      araddr_o,
    output dma_pkg::axi_len_t   arlen_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  dma_pkg::data_t      rdata_i,
    input  logic                rvalid_i,
    input  logic                rlast_i,
    output logic                rready_o,
    output dma_pkg::addr_t      awaddr_o,
    output dma_pkg::axi_len_t   awlen_o,
    output logic                awvalid_o,
    input  logic                awready_i,
    output dma_pkg::data_t      wdata_o,
    output logic                wlast_o,
    output logic                wvalid_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    import dma_pkg::*;

    logic  dma_en;
    logic  dma_fin;
    addr_t src_addr;
    addr_t dst_addr;
    qty_t  data_qty;

    dma_regs i_dma_regs (
        .clk         (clk),
        .rst         (rst),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .dma_fin_i   (dma_fin),
        .dma_en_o    (dma_en),
        .src_addr_o  (src_addr),
        .dst_addr_o  (dst_addr),
        .data_qty_o  (data_qty),
        .irq_o       (irq_o)
    );

    dma_master #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) i_dma_master (
        .clk        (clk),
        .rst        (rst),
        .dma_en_i   (dma_en),
        .src_addr_i (src_addr),
        .dst_addr_i (dst_addr),
        .data_qty_i (data_qty),
        .dma_fin_o  (dma_fin),
        .araddr_o   (araddr_o),
        .arlen_o    (arlen_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rvalid_i   (rvalid_i),
        .rlast_i    (rlast_i),
        .rready_o   (rready_o),
        .awaddr_o   (awaddr_o),
        .awlen_o    (awlen_o),
        .awvalid_o  (awvalid_o),
        .awready_i  (awready_i),
        .wdata_o    (wdata_o),
        .wlast_o    (wlast_o),
        .wvalid_o   (wvalid_o),
        .wready_i   (wready_i),
        .bvalid_i   (bvalid_i),
        .bready_o   (bready_o)
    );

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic               clk,
    input  logic               rst,
    input  dma_pkg::addr_t     araddr_i,
    input  dma_pkg::axi_len_t  arlen_i,
    input  logic               arvalid_i,
    output logic               arready_o,
    output dma_pkg::data_t     rdata_o,
    output logic               rvalid_o,
    output logic               rlast_o,
    input  logic               rready_i,
    input  dma_pkg::addr_t     awaddr_i,
    input  dma_pkg::axi_len_t  awlen_i,
    input  logic               awvalid_i,
    output logic               awready_o,
    input  dma_pkg::data_t     wdata_i,
    input  logic               wlast_i,
    input  logic               wvalid_i,
    output logic               wready_o,
    output logic               bvalid_o,
    input  logic               bready_i
);
    import dma_pkg::*;

    // sparse storage, one entry per word
    data_t mem [logic [29:0]];

    // chance of a stall in percent, raised by the testbench for heavy stalls
    int stall_pct = 25;

    addr_t      rd_addr_r;
    addr_t      wr_addr_r;
    logic [8:0] rd_left_r;
    logic [8:0] wr_left_r;
    logic       r_go_r;
    logic       w_go_r;
    logic       b_pend_r;

    function automatic logic go();
        return ($urandom % 100) >= stall_pct;
    endfunction

    function automatic void poke(addr_t a, data_t d);
        mem[a[31:2]] = d;
    endfunction

    // unwritten words read as x
    function automatic data_t peek(addr_t a);
        if (mem.exists(a[31:2])) begin
            return mem[a[31:2]];
        end
        return 'x;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready_o <= 1'b0;
            awready_o <= 1'b0;
            r_go_r    <= 1'b0;
            w_go_r    <= 1'b0;
            b_pend_r  <= 1'b0;
            rd_left_r <= '0;
            wr_left_r <= '0;
            rd_addr_r <= '0;
            wr_addr_r <= '0;
        end else begin
            arready_o <= go();
            awready_o <= go();
            // rvalid stays up until it is taken
            r_go_r    <= (rvalid_o && !rready_i) || go();
            w_go_r    <= go();
            if (arvalid_i && arready_o) begin
                rd_addr_r <= araddr_i;
                rd_left_r <= {1'b0, arlen_i} + 9'd1;
            end else if (rvalid_o && rready_i) begin
                rd_addr_r <= rd_addr_r + 32'd4;
                rd_left_r <= rd_left_r - 9'd1;
            end
            if (awvalid_i && awready_o) begin
                wr_addr_r <= awaddr_i;
                wr_left_r <= {1'b0, awlen_i} + 9'd1;
            end else if (wvalid_i && wready_o) begin
                poke(wr_addr_r, wdata_i);
                wr_addr_r <= wr_addr_r + 32'd4;
                wr_left_r <= wr_left_r - 9'd1;
                if (wlast_i) begin
                    b_pend_r <= 1'b1;
                end
            end
            if (bvalid_o && bready_i) begin
                b_pend_r <= 1'b0;
            end
        end
    end

    assign rdata_o  = peek(rd_addr_r);
    assign rvalid_o = (rd_left_r != '0) && r_go_r;
    assign rlast_o  = (rd_left_r == 9'd1);
    assign wready_o = (wr_left_r != '0) && w_go_r;
    assign bvalid_o = b_pend_r;

endmodule

//--- verif/dma_properties.sv
`timescale 1ns/1ps

module dma_properties (
    input  logic               clk,
    input  logic               rst,
    input  logic               arvalid_i,
    input  logic               arready_i,
    input  dma_pkg::addr_t     araddr_i,
    input  dma_pkg::axi_len_t  arlen_i,
    input  logic               awvalid_i,
    input  logic               awready_i,
    input  dma_pkg::addr_t     awaddr_i,
    input  dma_pkg::axi_len_t  awlen_i,
    input  logic               wvalid_i,
    input  logic               wready_i,
    input  logic               wlast_i,
    input  dma_pkg::data_t     wdata_i
);
    import dma_pkg::*;

    logic [8:0] beat_cnt_r;
    axi_len_t   len_r;
    logic       open_r;

    // write beats since the last AW transfer
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt_r <= '0;
            len_r      <= '0;
            open_r     <= 1'b0;
        end else if (awvalid_i && awready_i) begin
            beat_cnt_r <= '0;
            len_r      <= awlen_i;
            open_r     <= 1'b1;
        end else if (wvalid_i && wready_i) begin
            beat_cnt_r <= beat_cnt_r + 9'd1;
            if (wlast_i) begin
                open_r <= 1'b0;
            end
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arlen_i))
        else $error("arvalid dropped or payload changed before arready");

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
        else $error("awvalid dropped or payload changed before awready");

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i))
        else $error("wvalid dropped or wdata changed before wready");

    // a new burst only after the previous one saw wlast
    aw_after_last: assert property (@(posedge clk) disable iff (rst)
        awvalid_i && awready_i |-> !open_r)
        else $error("AW transfer before the previous burst ended");

    w_beat_count: assert property (@(posedge clk) disable iff (rst)
        wvalid_i && wready_i |-> open_r && (wlast_i == (beat_cnt_r == {1'b0, len_r})))
        else $error("write beat count does not match awlen");

endmodule

bind dma_master dma_properties i_dma_properties (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .araddr_i  (araddr_o),
    .arlen_i   (arlen_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .awaddr_i  (awaddr_o),
    .awlen_i   (awlen_o),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i),
    .wlast_i   (wlast_o),
    .wdata_i   (wdata_o)
);

//--- verif/dma_tb.sv
`timescale 1ns/1ps

module dma_tb;
    import dma_pkg::*;

    localparam int          CLK_PERIOD = 40;
    localparam logic [31:0] SEED       = 32'h9dd3c57b;

    logic      clk;
    logic      rst;
    logic      reg_we;
    reg_addr_t reg_addr;
    data_t     reg_wdata;
    data_t     reg_rdata;
    logic      irq;

    addr_t    araddr;
    addr_t    awaddr;
    axi_len_t arlen;
    axi_len_t awlen;
    data_t    rdata;
    data_t    wdata;
    logic     arvalid;
    logic     arready;
    logic     rvalid;
    logic     rlast;
    logic     rready;
    logic     awvalid;
    logic     awready;
    logic     wvalid;
    logic     wready;
    logic     wlast;
    logic     bvalid;
    logic     bready;

    int       errors;
    int       ar_cnt;
    int       valid_cycles;
    addr_t    ar_addr_q[$];
    axi_len_t ar_len_q[$];
    addr_t    aw_addr_q[$];
    axi_len_t aw_len_q[$];

    dma_top #(
        .FIFO_DEPTH_LOG2 (4)
    ) i_dma_top (
        .clk         (clk),
        .rst         (rst),
        .reg_we_i    (reg_we),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_rdata_o (reg_rdata),
        .irq_o       (irq),
        .araddr_o    (araddr),
        .arlen_o     (arlen),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .rdata_i     (rdata),
        .rvalid_i    (rvalid),
        .rlast_i     (rlast),
        .rready_o    (rready),
        .awaddr_o    (awaddr),
        .awlen_o     (awlen),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .wdata_o     (wdata),
        .wlast_o     (wlast),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .bvalid_i    (bvalid),
        .bready_o    (bready)
    );

    axi_mem_model i_mem (
        .clk       (clk),
        .rst       (rst),
        .araddr_i  (araddr),
        .arlen_i   (arlen),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .rdata_o   (rdata),
        .rvalid_o  (rvalid),
        .rlast_o   (rlast),
        .rready_i  (rready),
        .awaddr_i  (awaddr),
        .awlen_i   (awlen),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .wdata_i   (wdata),
        .wlast_i   (wlast),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .bvalid_o  (bvalid),
        .bready_i  (bready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // address channel log and activity
    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_cnt++;
            ar_addr_q.push_back(araddr);
            ar_len_q.push_back(arlen);
        end
        if (awvalid && awready) begin
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(awlen);
        end
        if (arvalid || awvalid) begin
            valid_cycles++;
        end
    end

    // source pattern over the whole address
    function automatic data_t src_word(addr_t a);
        return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    task automatic reg_write(reg_addr_t a, data_t d);
        @(posedge clk);
        #1;
        reg_we    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(posedge clk);
        #1;
        reg_we = 1'b0;
    endtask

    task automatic reg_read(reg_addr_t a, output data_t d);
        @(posedge clk);
        #1;
        reg_addr = a;
        #1;
        d = reg_rdata;
    endtask

    task automatic wait_irq(int max_cycles);
        int n;
        n = 0;
        while (!irq && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!irq) begin
            errors++;
            $display("timeout: irq_o did not rise within %0d cycles", max_cycles);
        end
    endtask

    task automatic start_copy(addr_t src, addr_t dst, int n);
        ar_cnt       = 0;
        valid_cycles = 0;
        ar_addr_q.delete();
        ar_len_q.delete();
        aw_addr_q.delete();
        aw_len_q.delete();
        for (int i = 0; i < n; i++) begin
            i_mem.poke(src + 4 * i, src_word(src + 4 * i));
        end
        reg_write(REG_SRC, src);
        reg_write(REG_DST, dst);
        reg_write(REG_QTY, n);
        reg_write(REG_CTRL, 32'h1);
    endtask

    task automatic compare_dst(addr_t src, addr_t dst, int n);
        data_t got;
        for (int i = 0; i < n; i++) begin
            got = i_mem.peek(dst + 4 * i);
            if (got !== src_word(src + 4 * i)) begin
                errors++;
                $display("error: mem[%h] got %h expected %h", dst + 4 * i, got,
                         src_word(src + 4 * i));
            end
        end
    endtask

    task automatic clear_irq();
        data_t rd;
        reg_write(REG_CTRL, 32'h2);
        reg_read(REG_CTRL, rd);
        if (irq !== 1'b0 || rd[1] !== 1'b0) begin
            errors++;
            $display("error: irq_o got %h ctrl got %h expected 0 and 0", irq, rd);
        end
    endtask

    task automatic test_readback();
        data_t rd;
        if (arvalid || awvalid || wvalid || rready || bready || irq) begin
            errors++;
            $display("error: arvalid,awvalid,wvalid,rready,bready,irq_o got %h expected %h",
                     {arvalid, awvalid, wvalid, rready, bready, irq}, 6'h0);
        end
        reg_read(REG_CTRL, rd);
        if (rd !== 32'h0) begin
            errors++;
            $display("error: ctrl got %h expected %h", rd, 32'h0);
        end
        reg_write(REG_SRC, 32'h12345670);
        reg_write(REG_DST, 32'habcd0000);
        reg_write(REG_QTY, 32'h00000077);
        reg_read(REG_SRC, rd);
        if (rd !== 32'h12345670) begin
            errors++;
            $display("error: src got %h expected %h", rd, 32'h12345670);
        end
        reg_read(REG_DST, rd);
        if (rd !== 32'habcd0000) begin
            errors++;
            $display("error: dst got %h expected %h", rd, 32'habcd0000);
        end
        reg_read(REG_QTY, rd);
        if (rd !== 32'h00000077) begin
            errors++;
            $display("error: qty got %h expected %h", rd, 32'h77);
        end
    endtask

    task automatic test_short();
        data_t rd;
        start_copy(32'h1000, 32'h8000, 5);
        wait_irq(2000);
        compare_dst(32'h1000, 32'h8000, 5);
        if (ar_cnt != 1) begin
            errors++;
            $display("error: ar count got %h expected %h", ar_cnt, 1);
        end else if (ar_len_q[0] !== 8'd4) begin
            errors++;
            $display("error: arlen got %h expected %h", ar_len_q[0], 8'd4);
        end
        reg_read(REG_CTRL, rd);
        if (rd !== 32'h2) begin
            errors++;
            $display("error: ctrl got %h expected %h", rd, 32'h2);
        end
        clear_irq();
    endtask

    task automatic test_multi();
        axi_len_t exp_len[3] = '{8'd255, 8'd255, 8'd87};
        start_copy(32'h10000, 32'h20000, 600);
        wait_irq(20000);
        if (ar_cnt != 3 || aw_addr_q.size() != 3) begin
            errors++;
            $display("error: ar count got %h aw count got %h expected %h", ar_cnt,
                     aw_addr_q.size(), 3);
        end else begin
            for (int i = 0; i < 3; i++) begin
                $display("ar %0d: araddr %h arlen %0d", i, ar_addr_q[i], ar_len_q[i]);
                if (ar_addr_q[i] !== 32'h10000 + 1024 * i || ar_len_q[i] !== exp_len[i]) begin
                    errors++;
                    $display("error: araddr/arlen got %h/%h expected %h/%h", ar_addr_q[i],
                             ar_len_q[i], 32'h10000 + 1024 * i, exp_len[i]);
                end
                if (aw_addr_q[i] !== 32'h20000 + 1024 * i || aw_len_q[i] !== exp_len[i]) begin
                    errors++;
                    $display("error: awaddr/awlen got %h/%h expected %h/%h", aw_addr_q[i],
                             aw_len_q[i], 32'h20000 + 1024 * i, exp_len[i]);
                end
            end
        end
        compare_dst(32'h10000, 32'h20000, 600);
        clear_irq();
    endtask

    task automatic test_zero();
        start_copy(32'h5000, 32'h6000, 0);
        wait_irq(100);
        if (valid_cycles != 0) begin
            errors++;
            $display("arvalid or awvalid was raised during a zero count copy");
        end
        clear_irq();
    endtask

    task automatic test_stall();
        i_mem.stall_pct = 70;
        start_copy(32'h30000, 32'h40000, 300);
        wait_irq(40000);
        compare_dst(32'h30000, 32'h40000, 300);
        i_mem.stall_pct = 25;
        clear_irq();
    endtask

    task automatic test_control();
        data_t rd;
        start_copy(32'h50000, 32'h60000, 20);
        reg_read(REG_CTRL, rd);
        if (rd[0] !== 1'b1) begin
            errors++;
            $display("error: ctrl got %h expected busy bit set", rd);
        end
        // second start while busy
        reg_write(REG_CTRL, 32'h1);
        wait_irq(2000);
        repeat (20) @(posedge clk);
        #1;
        if (ar_cnt != 1) begin
            errors++;
            $display("error: ar count got %h expected %h", ar_cnt, 1);
        end
        compare_dst(32'h50000, 32'h60000, 20);
        clear_irq();
    endtask

    initial begin
        void'($urandom(SEED));
        errors    = 0;
        ar_cnt    = 0;
        rst       = 1'b1;
        reg_we    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        test_readback();
        test_short();
        test_multi();
        test_zero();
        test_stall();
        test_control();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
